// ==== compile.f ====
+incdir+src
src/glb_pkg.sv
src/glb_bank_locator.sv
src/glb_bank.sv
src/glb_wr_port.sv
src/glb_rd_port.sv
src/glb_top.sv
sim/glb_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= glb_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= compile.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(wildcard src/*.sv src/*.svh sim/*.sv)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	-./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "sim passed" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/glb_tb.sv ====
`include "glb_config.svh"

`default_nettype none

module glb_tb;

    localparam int CLK_PERIOD = 4;
    localparam int XFER_CNT   = 32 + 1 + 33 + 2 * 40 + 2;
    localparam int TIMEOUT    = 40 * XFER_CNT * CLK_PERIOD;
    localparam int AW         = `GLB_ADDR_WIDTH;

    logic                                       clk;
    logic                                       rst_n;
    glb_pkg::glb_port_cfg_t [1:0]               wr_cfg_i;
    glb_pkg::glb_port_cfg_t [1:0]               rd_cfg_i;
    logic [1:0]                                 wr_vld_i;
    logic [1:0]                                 wr_rdy_o;
    glb_pkg::glb_wr_req_t [1:0]                 wr_req_i;
    logic [1:0]                                 wr_full_o;
    logic [1:0]                                 rd_addr_vld_i;
    logic [1:0]                                 rd_addr_rdy_o;
    logic [1:0][AW-1:0]                         rd_addr_i;
    logic [1:0]                                 rd_dat_vld_o;
    logic [1:0]                                 rd_dat_rdy_i;
    glb_pkg::glb_rd_data_t [1:0]                rd_dat_o;
    logic [1:0]                                 rd_empty_o;

    logic [31:0]    lfsr_q;
    logic [63:0]    ref_mem [2][64];
    string          test_name;

    glb_top dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr_cfg_i      (wr_cfg_i),
        .rd_cfg_i      (rd_cfg_i),
        .wr_vld_i      (wr_vld_i),
        .wr_rdy_o      (wr_rdy_o),
        .wr_req_i      (wr_req_i),
        .wr_full_o     (wr_full_o),
        .rd_addr_vld_i (rd_addr_vld_i),
        .rd_addr_rdy_o (rd_addr_rdy_o),
        .rd_addr_i     (rd_addr_i),
        .rd_dat_vld_o  (rd_dat_vld_o),
        .rd_dat_rdy_i  (rd_dat_rdy_i),
        .rd_dat_o      (rd_dat_o),
        .rd_empty_o    (rd_empty_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ==========================================================
    // Checking helpers
    // ==========================================================

    task automatic check_eq(input string what, input logic [63:0] exp, input logic [63:0] act);
        assert (exp === act) else begin
            $display("FAILED %s (%s): expected %h actual %h", test_name, what, exp, act);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    task automatic check_true(input string msg, input logic cond);
        assert (cond === 1'b1) else begin
            $display("Error in %s: %s", test_name, msg);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    // Galois LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v      = {v[62:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    // Words beyond the port parallelism read back as zero
    function automatic logic [63:0] par_mask(input int p);
        par_mask = (p == 0) ? 64'h0000_0000_ffff_ffff : 64'h0000_0000_0000_ffff;
    endfunction

    // ==========================================================
    // Transfer tasks
    // ==========================================================

    task automatic do_write(input int p, input int addr);
        glb_pkg::glb_wr_req_t   req;
        logic [63:0]            rnd;
        draw_bits(64, rnd);
        req.addr = AW'(addr);
        req.data = rnd;
        @(posedge clk);
        wr_req_i[p] <= req;
        wr_vld_i[p] <= 1'b1;
        do @(negedge clk); while (wr_rdy_o[p] !== 1'b1);
        @(posedge clk);
        wr_vld_i[p]          <= 1'b0;
        ref_mem[p][addr % 64] = rnd & par_mask(p);
    endtask

    // Leaves the caller at the negedge where read data must be valid
    task automatic do_read(input int p, input int addr);
        @(posedge clk);
        rd_addr_i[p]     <= AW'(addr);
        rd_addr_vld_i[p] <= 1'b1;
        do @(negedge clk); while (rd_addr_rdy_o[p] !== 1'b1);
        @(posedge clk);
        rd_addr_vld_i[p] <= 1'b0;
        @(negedge clk);
        check_true("read data not valid one cycle after address", rd_dat_vld_o[p]);
        check_eq($sformatf("data port %0d addr %0d", p, addr), ref_mem[p][addr % 64],
                 rd_dat_o[p]);
    endtask

    // Ready and valid stay low while reset is applied
    always @(negedge clk) begin
        if (!rst_n) begin
            check_eq("wr_rdy_o in reset", 64'd0, 64'(wr_rdy_o));
            check_eq("rd_addr_rdy_o in reset", 64'd0, 64'(rd_addr_rdy_o));
            check_eq("rd_dat_vld_o in reset", 64'd0, 64'(rd_dat_vld_o));
        end
    end

    initial begin
        #(TIMEOUT);
        $display("Error: watchdog expired before the tests completed");
        $display("sim failed");
        $fatal(1);
    end

    // ==========================================================
    // Test sequence
    // ==========================================================

    initial begin
        logic [63:0] held;

        clk           = 1'b0;
        rst_n         = 1'b0;
        lfsr_q        = 32'h8f99_4cad;
        wr_cfg_i[0]   = '{bank_mask: 8'h0f, par: 3'd2};
        rd_cfg_i[0]   = '{bank_mask: 8'h0f, par: 3'd2};
        wr_cfg_i[1]   = '{bank_mask: 8'hf0, par: 3'd1};
        rd_cfg_i[1]   = '{bank_mask: 8'hf0, par: 3'd1};
        wr_vld_i      = '0;
        wr_req_i      = '0;
        rd_addr_vld_i = '0;
        rd_addr_i     = '0;
        rd_dat_rdy_i  = 2'b11;
        test_name     = "reset";

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        test_name = "reset_empty";
        repeat (2) @(negedge clk);
        check_eq("rd_empty_o", 64'h3, 64'(rd_empty_o));
        check_eq("rd_addr_rdy_o", 64'h0, 64'(rd_addr_rdy_o));
        check_eq("rd_dat_vld_o", 64'h0, 64'(rd_dat_vld_o));

        // Fill the whole 32 entry ring of port 0
        test_name = "round_trip_p0";
        for (int a = 0; a < 32; a++) begin
            do_write(0, a);
        end

        test_name = "full_flag";
        draw_bits(64, held);
        @(posedge clk);
        wr_req_i[0].addr <= AW'(32);
        wr_req_i[0].data <= held;
        wr_vld_i[0]      <= 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_true("full not raised after a whole ring", wr_full_o[0]);
            check_true("write ready high while full", !wr_rdy_o[0]);
        end
        do_read(0, 0);
        check_true("full still high after one read", !wr_full_o[0]);
        while (wr_rdy_o[0] !== 1'b1) begin
            @(negedge clk);
        end
        @(posedge clk);
        wr_vld_i[0]    <= 1'b0;
        ref_mem[0][32]  = held & par_mask(0);

        test_name = "round_trip_p0";
        for (int a = 1; a <= 32; a++) begin
            do_read(0, a);
        end
        @(posedge clk);
        rd_addr_i[0] <= AW'(33);
        @(negedge clk);
        check_true("read port 0 not empty after draining", rd_empty_o[0]);

        // Parallelism 1 walks from bank 4 into bank 6
        test_name = "port_independence";
        for (int a = 0; a < 40; a++) begin
            do_write(1, a);
        end
        for (int a = 0; a < 40; a++) begin
            do_read(1, a);
            check_true("port 0 empty disturbed by port 1", rd_empty_o[0]);
            check_true("port 0 full disturbed by port 1", !wr_full_o[0]);
        end

        test_name = "back_pressure";
        do_write(1, 40);
        @(posedge clk);
        rd_dat_rdy_i[1] <= 1'b0;
        do_read(1, 40);
        repeat (5) begin
            @(negedge clk);
            check_true("read data dropped while held", rd_dat_vld_o[1]);
            check_eq("held read data", ref_mem[1][40], rd_dat_o[1]);
        end
        @(posedge clk);
        rd_dat_rdy_i[1] <= 1'b1;
        @(negedge clk);
        @(negedge clk);
        check_true("read data still valid after ready", !rd_dat_vld_o[1]);

        // Port 1 loses its banks while idle
        test_name = "unallocated_port";
        @(posedge clk);
        wr_cfg_i[1]      <= '{bank_mask: 8'h00, par: 3'd1};
        rd_cfg_i[1]      <= '{bank_mask: 8'h00, par: 3'd1};
        rd_addr_i[1]     <= AW'(0);
        wr_vld_i[1]      <= 1'b1;
        rd_addr_vld_i[1] <= 1'b1;
        repeat (8) begin
            @(negedge clk);
            check_true("unallocated write port shows ready", !wr_rdy_o[1]);
            check_true("unallocated read port shows ready", !rd_addr_rdy_o[1]);
        end
        @(posedge clk);
        wr_vld_i[1]      <= 1'b0;
        rd_addr_vld_i[1] <= 1'b0;

        @(posedge clk);
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/glb_top.sv ====
`include "glb_config.svh"

`default_nettype none

module glb_top (
    input  wire logic                                           clk,
    input  wire logic                                           rst_n,
    input  wire glb_pkg::glb_port_cfg_t [`GLB_NUM_WRPORT-1:0]   wr_cfg_i,
    input  wire glb_pkg::glb_port_cfg_t [`GLB_NUM_RDPORT-1:0]   rd_cfg_i,
    input  wire logic [`GLB_NUM_WRPORT-1:0]                     wr_vld_i,
    output logic [`GLB_NUM_WRPORT-1:0]                          wr_rdy_o,
    input  wire glb_pkg::glb_wr_req_t [`GLB_NUM_WRPORT-1:0]     wr_req_i,
    output logic [`GLB_NUM_WRPORT-1:0]                          wr_full_o,
    input  wire logic [`GLB_NUM_RDPORT-1:0]                     rd_addr_vld_i,
    output logic [`GLB_NUM_RDPORT-1:0]                          rd_addr_rdy_o,
    input  wire logic [`GLB_NUM_RDPORT-1:0][`GLB_ADDR_WIDTH-1:0] rd_addr_i,
    output logic [`GLB_NUM_RDPORT-1:0]                          rd_dat_vld_o,
    input  wire logic [`GLB_NUM_RDPORT-1:0]                     rd_dat_rdy_i,
    output glb_pkg::glb_rd_data_t [`GLB_NUM_RDPORT-1:0]         rd_dat_o,
    output logic [`GLB_NUM_RDPORT-1:0]                          rd_empty_o
);

    localparam int NB       = `GLB_NUM_BANK;
    localparam int NWR      = `GLB_NUM_WRPORT;
    localparam int NRD      = `GLB_NUM_RDPORT;
    localparam int WR_SEL_W = (NWR > 1) ? $clog2(NWR) : 1;
    localparam int RD_SEL_W = (NRD > 1) ? $clog2(NRD) : 1;

    // Per port strobes towards the banks
    logic [NWR-1:0][NB-1:0]                     wp_bank_wr_vld;
    glb_pkg::glb_bank_wr_t [NWR-1:0][NB-1:0]    wp_bank_wr;
    logic [NRD-1:0][NB-1:0]                     rp_bank_rd_vld;
    glb_pkg::glb_bank_rd_t [NRD-1:0]            rp_bank_rd;
    logic [NRD-1:0][NB-1:0]                     rp_bank_dat_rdy;

    // Per bank state back to the ports
    logic [NB-1:0]                              bank_wr_rdy;
    logic [NB-1:0]                              bank_addr_rdy;
    logic [NB-1:0]                              bank_dat_vld;
    logic [NB-1:0][`GLB_BANK_WIDTH-1:0]         bank_dat;
    logic [NB-1:0][`GLB_ADDR_WIDTH-1:0]         bank_wr_next;
    logic [NB-1:0][`GLB_ADDR_WIDTH-1:0]         bank_rd_next;

    // ==========================================================
    // Port mappers
    // ==========================================================

    for (genvar p = 0; p < NWR; p++) begin : g_wr_port
        glb_wr_port u_wr_port (
            .cfg_i          (wr_cfg_i[p]),
            .wr_vld_i       (wr_vld_i[p]),
            .wr_rdy_o       (wr_rdy_o[p]),
            .wr_full_o      (wr_full_o[p]),
            .wr_req_i       (wr_req_i[p]),
            .bank_rdy_i     (bank_wr_rdy),
            .bank_rd_next_i (bank_rd_next),
            .bank_wr_vld_o  (wp_bank_wr_vld[p]),
            .bank_wr_o      (wp_bank_wr[p])
        );
    end

    for (genvar p = 0; p < NRD; p++) begin : g_rd_port
        glb_rd_port u_rd_port (
            .cfg_i           (rd_cfg_i[p]),
            .rd_addr_vld_i   (rd_addr_vld_i[p]),
            .rd_addr_rdy_o   (rd_addr_rdy_o[p]),
            .rd_empty_o      (rd_empty_o[p]),
            .rd_addr_i       (rd_addr_i[p]),
            .bank_addr_rdy_i (bank_addr_rdy),
            .bank_wr_next_i  (bank_wr_next),
            .bank_rd_vld_o   (rp_bank_rd_vld[p]),
            .bank_rd_o       (rp_bank_rd[p]),
            .bank_dat_vld_i  (bank_dat_vld),
            .bank_dat_i      (bank_dat),
            .bank_dat_rdy_o  (rp_bank_dat_rdy[p]),
            .rd_dat_vld_o    (rd_dat_vld_o[p]),
            .rd_dat_rdy_i    (rd_dat_rdy_i[p]),
            .rd_dat_o        (rd_dat_o[p])
        );
    end

    // ==========================================================
    // Banks with static owner selection
    // ==========================================================

    for (genvar b = 0; b < NB; b++) begin : g_bank
        logic [WR_SEL_W-1:0]    wr_sel;
        logic [RD_SEL_W-1:0]    rd_sel;
        logic                   wr_owned;
        logic                   rd_owned;

        // Lowest numbered port claiming this bank wins
        always_comb begin
            wr_sel   = '0;
            wr_owned = 1'b0;
            for (int p = NWR - 1; p >= 0; p--) begin
                if (wr_cfg_i[p].bank_mask[b]) begin
                    wr_sel   = WR_SEL_W'(p);
                    wr_owned = 1'b1;
                end
            end
        end

        always_comb begin
            rd_sel   = '0;
            rd_owned = 1'b0;
            for (int p = NRD - 1; p >= 0; p--) begin
                if (rd_cfg_i[p].bank_mask[b]) begin
                    rd_sel   = RD_SEL_W'(p);
                    rd_owned = 1'b1;
                end
            end
        end

        glb_bank u_bank (
            .clk           (clk),
            .rst_n         (rst_n),
            .wr_vld_i      (wr_owned & wp_bank_wr_vld[wr_sel][b]),
            .wr_rdy_o      (bank_wr_rdy[b]),
            .wr_i          (wp_bank_wr[wr_sel][b]),
            .rd_addr_vld_i (rd_owned & rp_bank_rd_vld[rd_sel][b]),
            .rd_addr_rdy_o (bank_addr_rdy[b]),
            .rd_i          (rp_bank_rd[rd_sel]),
            .rd_dat_vld_o  (bank_dat_vld[b]),
            .rd_dat_rdy_i  (rd_owned & rp_bank_dat_rdy[rd_sel][b]),
            .rd_dat_o      (bank_dat[b]),
            .wr_next_o     (bank_wr_next[b]),
            .rd_next_o     (bank_rd_next[b])
        );
    end

endmodule

`default_nettype wire

// ==== src/glb_rd_port.sv ====
`include "glb_config.svh"

`default_nettype none

module glb_rd_port (
    input  wire glb_pkg::glb_port_cfg_t                         cfg_i,
    input  wire logic                                           rd_addr_vld_i,
    output logic                                                rd_addr_rdy_o,
    output logic                                                rd_empty_o,
    input  wire logic [`GLB_ADDR_WIDTH-1:0]                     rd_addr_i,
    input  wire logic [`GLB_NUM_BANK-1:0]                       bank_addr_rdy_i,
    input  wire logic [`GLB_NUM_BANK-1:0][`GLB_ADDR_WIDTH-1:0]  bank_wr_next_i,
    output logic [`GLB_NUM_BANK-1:0]                            bank_rd_vld_o,
    output glb_pkg::glb_bank_rd_t                               bank_rd_o,
    input  wire logic [`GLB_NUM_BANK-1:0]                       bank_dat_vld_i,
    input  wire logic [`GLB_NUM_BANK-1:0][`GLB_BANK_WIDTH-1:0]  bank_dat_i,
    output logic [`GLB_NUM_BANK-1:0]                            bank_dat_rdy_o,
    output logic                                                rd_dat_vld_o,
    input  wire logic                                           rd_dat_rdy_i,
    output glb_pkg::glb_rd_data_t                               rd_dat_o
);

    localparam int NB    = `GLB_NUM_BANK;
    localparam int IDX_W = `GLB_BANK_IDX_W;
    localparam int AW    = `GLB_ADDR_WIDTH;

    logic [IDX_W-1:0]   first_bank;
    logic [IDX_W:0]     bank_cnt;
    logic [AW-1:0]      ring_size;
    logic [AW-1:0]      group;
    logic [IDX_W-1:0]   cur_first;
    logic [IDX_W-1:0]   dat_first;
    logic [NB-1:0]      hit;
    logic               alloc;
    logic               held;
    logic               slot_free;
    logic               issue;

    glb_bank_locator u_locator (
        .cfg_i        (cfg_i),
        .first_bank_o (first_bank),
        .bank_cnt_o   (bank_cnt),
        .ring_size_o  (ring_size)
    );

    assign alloc = bank_cnt != '0;

    // ==========================================================
    // Address side
    // ==========================================================

    assign group     = (rd_addr_i % ring_size) >> `GLB_BANK_AW;
    assign cur_first = first_bank + IDX_W'(group * AW'(cfg_i.par));

    always_comb begin
        for (int b = 0; b < NB; b++) begin
            hit[b] = (b >= int'(cur_first)) && (b < int'(cur_first) + int'(cfg_i.par));
        end
    end

    // Caught up with the writes of this group
    assign rd_empty_o = rd_addr_i >= bank_wr_next_i[cur_first];

    // Only one group of read data in flight per port
    assign held      = |(bank_dat_vld_i & cfg_i.bank_mask);
    assign slot_free = ~held | rd_dat_rdy_i;
    assign issue     = alloc & ~rd_empty_o & slot_free;

    assign rd_addr_rdy_o       = issue & bank_addr_rdy_i[cur_first];
    assign bank_rd_vld_o       = {NB{rd_addr_vld_i & issue}} & hit;
    assign bank_rd_o.raddr     = rd_addr_i[`GLB_BANK_AW-1:0];
    assign bank_rd_o.port_addr = rd_addr_i;

    // ==========================================================
    // Data side
    // ==========================================================

    assign bank_dat_rdy_o = {NB{rd_dat_rdy_i}} & cfg_i.bank_mask;
    assign rd_dat_vld_o   = held;

    // Lowest valid owned bank leads the pending group
    always_comb begin
        dat_first = '0;
        for (int b = NB - 1; b >= 0; b--) begin
            if (bank_dat_vld_i[b] && cfg_i.bank_mask[b]) begin
                dat_first = IDX_W'(b);
            end
        end
    end

    always_comb begin
        for (int k = 0; k < `GLB_MAXPAR; k++) begin
            if (k < int'(cfg_i.par)) begin
                rd_dat_o.word[k] = bank_dat_i[dat_first + IDX_W'(k)];
            end else begin
                rd_dat_o.word[k] = '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/glb_wr_port.sv ====
`include "glb_config.svh"

`default_nettype none

module glb_wr_port (
    input  wire glb_pkg::glb_port_cfg_t                         cfg_i,
    input  wire logic                                           wr_vld_i,
    output logic                                                wr_rdy_o,
    output logic                                                wr_full_o,
    input  wire glb_pkg::glb_wr_req_t                           wr_req_i,
    input  wire logic [`GLB_NUM_BANK-1:0]                       bank_rdy_i,
    input  wire logic [`GLB_NUM_BANK-1:0][`GLB_ADDR_WIDTH-1:0]  bank_rd_next_i,
    output logic [`GLB_NUM_BANK-1:0]                            bank_wr_vld_o,
    output glb_pkg::glb_bank_wr_t [`GLB_NUM_BANK-1:0]           bank_wr_o
);

    localparam int NB     = `GLB_NUM_BANK;
    localparam int IDX_W  = `GLB_BANK_IDX_W;
    localparam int AW     = `GLB_ADDR_WIDTH;
    localparam int SLOT_W = (`GLB_MAXPAR > 1) ? $clog2(`GLB_MAXPAR) : 1;

    logic [IDX_W-1:0]   first_bank;
    logic [IDX_W:0]     bank_cnt;
    logic [AW-1:0]      ring_size;
    logic [AW-1:0]      group;
    logic [IDX_W-1:0]   cur_first;
    logic [NB-1:0]      hit;
    logic [AW-1:0]      lag;
    logic               alloc;

    glb_bank_locator u_locator (
        .cfg_i        (cfg_i),
        .first_bank_o (first_bank),
        .bank_cnt_o   (bank_cnt),
        .ring_size_o  (ring_size)
    );

    assign alloc = bank_cnt != '0;

    // ==========================================================
    // Address to bank group
    // ==========================================================

    assign group     = (wr_req_i.addr % ring_size) >> `GLB_BANK_AW;
    assign cur_first = first_bank + IDX_W'(group * AW'(cfg_i.par));

    always_comb begin
        for (int b = 0; b < NB; b++) begin
            hit[b] = (b >= int'(cur_first)) && (b < int'(cur_first) + int'(cfg_i.par));
        end
    end

    // A whole ring ahead of the reads of this group
    assign lag       = wr_req_i.addr - bank_rd_next_i[cur_first];
    assign wr_full_o = lag == ring_size;

    assign wr_rdy_o      = alloc & ~wr_full_o & bank_rdy_i[cur_first];
    assign bank_wr_vld_o = {NB{wr_vld_i & alloc & ~wr_full_o}} & hit;

    // Slot k of the request goes to bank cur_first + k
    always_comb begin
        logic [SLOT_W-1:0] slot;
        for (int b = 0; b < NB; b++) begin
            slot                   = SLOT_W'(IDX_W'(b) - cur_first);
            bank_wr_o[b].waddr     = wr_req_i.addr[`GLB_BANK_AW-1:0];
            bank_wr_o[b].wdata     = wr_req_i.data[slot];
            bank_wr_o[b].port_addr = wr_req_i.addr;
        end
    end

endmodule

`default_nettype wire

// ==== src/glb_bank.sv ====
`include "glb_config.svh"

`default_nettype none

module glb_bank (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       wr_vld_i,
    output logic                            wr_rdy_o,
    input  wire glb_pkg::glb_bank_wr_t      wr_i,
    input  wire logic                       rd_addr_vld_i,
    output logic                            rd_addr_rdy_o,
    input  wire glb_pkg::glb_bank_rd_t      rd_i,
    output logic                            rd_dat_vld_o,
    input  wire logic                       rd_dat_rdy_i,
    output logic [`GLB_BANK_WIDTH-1:0]      rd_dat_o,
    output logic [`GLB_ADDR_WIDTH-1:0]      wr_next_o,
    output logic [`GLB_ADDR_WIDTH-1:0]      rd_next_o
);

    logic [`GLB_BANK_WIDTH-1:0] mem [`GLB_BANK_WORDS];
    logic                       run_q;
    logic                       wr_fire;
    logic                       rd_fire;

    // Ready rises one cycle out of reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
        end
    end

    assign wr_rdy_o      = run_q;
    // No new address while the output word is held
    assign rd_addr_rdy_o = run_q & (~rd_dat_vld_o | rd_dat_rdy_i);

    assign wr_fire = wr_vld_i & wr_rdy_o;
    assign rd_fire = rd_addr_vld_i & rd_addr_rdy_o;

    // ==========================================================
    // Storage and read output register
    // ==========================================================

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[wr_i.waddr] <= wr_i.wdata;
        end
        if (rd_fire) begin
            rd_dat_o <= mem[rd_i.raddr];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_dat_vld_o <= 1'b0;
        end else if (rd_fire) begin
            rd_dat_vld_o <= 1'b1;
        end else if (rd_dat_rdy_i) begin
            rd_dat_vld_o <= 1'b0;
        end
    end

    // ==========================================================
    // Progress pointers
    // ==========================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_next_o <= '0;
        end else if (wr_fire) begin
            wr_next_o <= wr_i.port_addr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_next_o <= '0;
        end else if (rd_fire) begin
            rd_next_o <= rd_i.port_addr + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== src/glb_bank_locator.sv ====
`include "glb_config.svh"

`default_nettype none

module glb_bank_locator (
    input  wire glb_pkg::glb_port_cfg_t     cfg_i,
    output logic [`GLB_BANK_IDX_W-1:0]      first_bank_o,
    output logic [`GLB_BANK_IDX_W:0]        bank_cnt_o,
    output logic [`GLB_ADDR_WIDTH-1:0]      ring_size_o
);

    localparam int IDX_W = `GLB_BANK_IDX_W;
    localparam int CNT_W = `GLB_BANK_IDX_W + 1;
    localparam int AW    = `GLB_ADDR_WIDTH;

    logic [AW-1:0] span;

    // Lowest set bit is the base of the ring
    always_comb begin
        first_bank_o = '0;
        for (int i = `GLB_NUM_BANK - 1; i >= 0; i--) begin
            if (cfg_i.bank_mask[i]) begin
                first_bank_o = IDX_W'(i);
            end
        end
    end

    always_comb begin
        bank_cnt_o = '0;
        for (int i = 0; i < `GLB_NUM_BANK; i++) begin
            bank_cnt_o = bank_cnt_o + CNT_W'(cfg_i.bank_mask[i]);
        end
    end

    // One ring slot row spans par banks
    assign span        = AW'(`GLB_BANK_WORDS) * AW'(bank_cnt_o);
    assign ring_size_o = (bank_cnt_o == '0 || cfg_i.par == '0) ? AW'(`GLB_BANK_WORDS)
                                                               : span / AW'(cfg_i.par);

endmodule

`default_nettype wire

// ==== src/glb_pkg.sv ====
`include "glb_config.svh"

`default_nettype none

package glb_pkg;

    // ==========================================================
    // Port configuration
    // ==========================================================

    // Banks owned by the port and banks covered per access
    typedef struct packed {
        logic [`GLB_NUM_BANK-1:0]   bank_mask;
        logic [`GLB_PAR_W-1:0]      par;
    } glb_port_cfg_t;

    // ==========================================================
    // Port traffic
    // ==========================================================

    // Word k lands in the k-th bank of the active group
    typedef struct packed {
        logic [`GLB_ADDR_WIDTH-1:0]                     addr;
        logic [`GLB_MAXPAR-1:0][`GLB_BANK_WIDTH-1:0]    data;
    } glb_wr_req_t;

    typedef struct packed {
        logic [`GLB_MAXPAR-1:0][`GLB_BANK_WIDTH-1:0]    word;
    } glb_rd_data_t;

    // ==========================================================
    // Bank traffic
    // ==========================================================

    // Full port address rides along for the progress pointers
    typedef struct packed {
        logic [`GLB_BANK_AW-1:0]        waddr;
        logic [`GLB_BANK_WIDTH-1:0]     wdata;
        logic [`GLB_ADDR_WIDTH-1:0]     port_addr;
    } glb_bank_wr_t;

    typedef struct packed {
        logic [`GLB_BANK_AW-1:0]        raddr;
        logic [`GLB_ADDR_WIDTH-1:0]     port_addr;
    } glb_bank_rd_t;

endpackage

`default_nettype wire

// ==== src/glb_config.svh ====
`ifndef GLB_CONFIG_SVH
`define GLB_CONFIG_SVH

`default_nettype none

// Bank pool geometry
`define GLB_NUM_BANK        8
`define GLB_BANK_WIDTH      16
// Words per bank must be a power of two
`define GLB_BANK_WORDS      16

// Port side
`define GLB_ADDR_WIDTH      12
`define GLB_NUM_WRPORT      2
`define GLB_NUM_RDPORT      2
`define GLB_MAXPAR          4

// Derived widths
`define GLB_BANK_IDX_W      ($clog2(`GLB_NUM_BANK))
`define GLB_BANK_AW         ($clog2(`GLB_BANK_WORDS))
`define GLB_PAR_W           ($clog2(`GLB_MAXPAR) + 1)

`default_nettype wire

`endif
